//--- hw/core_pkg.sv
package core_pkg;

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int reg_count  = 32;
	localparam int opcode_w   = 6;
	localparam int funct_w    = 6;
	localparam int imm_w      = 16;
	localparam int apb_addr_w = 12;
	localparam int status_w   = 2;
	localparam int pipe_depth = 3;	// Decode, execute, result

	localparam logic [opcode_w-1:0] op_rtype = 6'h00;
	localparam logic [opcode_w-1:0] op_ldb   = 6'h20;
	localparam logic [opcode_w-1:0] op_ldw   = 6'h23;
	localparam logic [opcode_w-1:0] op_stb   = 6'h28;
	localparam logic [opcode_w-1:0] op_stw   = 6'h2b;
	localparam logic [opcode_w-1:0] op_beq   = 6'h04;
	localparam logic [opcode_w-1:0] op_bne   = 6'h05;
	localparam logic [opcode_w-1:0] op_jump  = 6'h02;
	localparam logic [opcode_w-1:0] op_li    = 6'h18;
	localparam logic [opcode_w-1:0] op_addi  = 6'h08;
	localparam logic [opcode_w-1:0] op_lui   = 6'h0f;
	localparam logic [opcode_w-1:0] op_ori   = 6'h0d;

	localparam logic [funct_w-1:0] fn_add = 6'h20;
	localparam logic [funct_w-1:0] fn_sub = 6'h22;
	localparam logic [funct_w-1:0] fn_and = 6'h24;
	localparam logic [funct_w-1:0] fn_or  = 6'h25;
	localparam logic [funct_w-1:0] fn_slt = 6'h2a;

	// Instruction field bit positions
	localparam int op_msb  = 31, op_lsb  = 26;
	localparam int rs_msb  = 25, rs_lsb  = 21;
	localparam int rt_msb  = 20, rt_lsb  = 16;
	localparam int rd_msb  = 15, rd_lsb  = 11;
	localparam int fn_msb  = 5,  fn_lsb  = 0;
	localparam int imm_msb = 15, imm_lsb = 0;

	localparam logic [1:0] imm_sext  = 2'd0;	// Sign-extend
	localparam logic [1:0] imm_zext  = 2'd1;	// Zero-extend
	localparam logic [1:0] imm_upper = 2'd2;	// Shift left by 16

	localparam int dmem_bytes  = 256;
	localparam int dmem_addr_w = 8;	// Byte addresses wrap modulo dmem_bytes

	localparam logic [apb_addr_w-1:0] addr_instr    = 12'h000;	// Write only
	localparam logic [apb_addr_w-1:0] addr_status   = 12'h004;	// Read only
	localparam logic [apb_addr_w-1:0] addr_reg_base = 12'h080;	// Register r at base + 4*r

	localparam int st_taken   = 0;
	localparam int st_illegal = 1;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [reg_addr_w-1:0] raddr_a,
	input  logic [reg_addr_w-1:0] raddr_b,
	input  logic [reg_addr_w-1:0] raddr_dbg,	// Host read port behind APB
	input  logic                  we,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [data_w-1:0]     wdata,
	output logic [data_w-1:0]     rdata_a,
	output logic [data_w-1:0]     rdata_b,
	output logic [data_w-1:0]     rdata_dbg
);
	logic [data_w-1:0] regs [reg_count];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;	// r0 is never written so it reads as zero
		end
	end

	assign rdata_a   = regs[raddr_a];
	assign rdata_b   = regs[raddr_b];
	assign rdata_dbg = regs[raddr_dbg];

endmodule

//--- hw/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,	// A cycle without issue is a stall
	input  logic [data_w-1:0]     instr,
	output logic                  valid,
	output logic                  regwrite,	// Write-back enable
	output logic                  memtoreg,	// Write-back takes the load data
	output logic                  branch,
	output logic                  branch_ne,	// Compare is inverted for BNE
	output logic                  memwrite,
	output logic                  memread,
	output logic                  byteword,	// Word access when high
	output logic                  alusrc,	// Second operand from a register when high
	output logic                  illegal,
	output logic [reg_addr_w-1:0] rs,
	output logic [reg_addr_w-1:0] rt,
	output logic [reg_addr_w-1:0] dest,
	output logic [funct_w-1:0]    funct,
	output logic [imm_w-1:0]      imm,
	output logic [1:0]            imm_mode
);
	logic [opcode_w-1:0] opcode;

	assign opcode = instr[op_msb:op_lsb];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid     <= 1'b0;
			regwrite  <= 1'b0;
			memtoreg  <= 1'b0;
			branch    <= 1'b0;
			branch_ne <= 1'b0;
			memwrite  <= 1'b0;
			memread   <= 1'b0;
			byteword  <= 1'b0;
			alusrc    <= 1'b0;
			illegal   <= 1'b0;
			imm_mode  <= imm_sext;
		end else if (!issue) begin
			valid    <= 1'b0;	// Stall, so nothing may write
			regwrite <= 1'b0;
			memwrite <= 1'b0;
			memread  <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			valid     <= 1'b1;
			regwrite  <= 1'b0;
			memtoreg  <= 1'b0;
			branch    <= 1'b0;
			branch_ne <= 1'b0;
			memwrite  <= 1'b0;
			memread   <= 1'b0;
			byteword  <= 1'b0;
			alusrc    <= 1'b0;
			illegal   <= 1'b0;
			imm_mode  <= imm_sext;
			case (opcode)
				op_rtype: begin
					regwrite <= 1'b1;
					alusrc   <= 1'b1;
				end
				op_ldb, op_ldw: begin
					regwrite <= 1'b1;
					memtoreg <= 1'b1;
					memread  <= 1'b1;
					byteword <= (opcode == op_ldw);
				end
				op_stb, op_stw: begin
					memwrite <= 1'b1;
					byteword <= (opcode == op_stw);
				end
				op_beq, op_bne: begin
					branch    <= 1'b1;
					branch_ne <= (opcode == op_bne);
					alusrc    <= 1'b1;
				end
				op_jump: ;	// Retires without effect, there is no PC
				op_li, op_addi: regwrite <= 1'b1;
				op_lui: begin
					regwrite <= 1'b1;
					imm_mode <= imm_upper;
				end
				op_ori: begin
					regwrite <= 1'b1;
					imm_mode <= imm_zext;
				end
				default: illegal <= 1'b1;	// Unknown opcode enables nothing
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			rs    <= (opcode == op_li) ? '0 : instr[rs_msb:rs_lsb];	// LI adds to r0
			rt    <= instr[rt_msb:rt_lsb];
			dest  <= (opcode == op_rtype) ? instr[rd_msb:rd_lsb] : instr[rt_msb:rt_lsb];
			funct <= instr[fn_msb:fn_lsb];
			imm   <= instr[imm_msb:imm_lsb];
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(memread && memwrite));

endmodule

//--- hw/execute_alu.sv
`timescale 1ns/1ps

module execute_alu import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid,
	input  logic                  regwrite,
	input  logic                  memtoreg,
	input  logic                  branch,
	input  logic                  branch_ne,
	input  logic                  memwrite,
	input  logic                  memread,
	input  logic                  byteword,
	input  logic                  alusrc,
	input  logic                  illegal,
	input  logic [reg_addr_w-1:0] rs,
	input  logic [reg_addr_w-1:0] rt,
	input  logic [reg_addr_w-1:0] dest,
	input  logic [funct_w-1:0]    funct,
	input  logic [imm_w-1:0]      imm,
	input  logic [1:0]            imm_mode,
	input  logic [data_w-1:0]     rdata_a,
	input  logic [data_w-1:0]     rdata_b,
	output logic [reg_addr_w-1:0] raddr_a,
	output logic [reg_addr_w-1:0] raddr_b,
	output logic                  ex_valid,
	output logic                  ex_regwrite,
	output logic                  ex_memtoreg,
	output logic                  ex_memwrite,
	output logic                  ex_memread,
	output logic                  ex_byteword,
	output logic [reg_addr_w-1:0] ex_dest,
	output logic                  ex_illegal,
	output logic [data_w-1:0]     alu_result,
	output logic [data_w-1:0]     store_data,
	output logic                  taken
);
	logic [data_w-1:0] ext_imm;
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] result;

	assign raddr_a = rs;
	assign raddr_b = rt;

	always_comb begin
		case (imm_mode)
			imm_zext:  ext_imm = {{(data_w-imm_w){1'b0}}, imm};
			imm_upper: ext_imm = {imm, {(data_w-imm_w){1'b0}}};
			default:   ext_imm = {{(data_w-imm_w){imm[imm_w-1]}}, imm};
		endcase
		op_b = alusrc ? rdata_b : ext_imm;
		if (alusrc) begin
			case (funct)
				fn_add:  result = rdata_a + op_b;
				fn_sub:  result = rdata_a - op_b;
				fn_and:  result = rdata_a & op_b;
				fn_or:   result = rdata_a | op_b;
				fn_slt:  result = {{(data_w-1){1'b0}}, $signed(rdata_a) < $signed(op_b)};
				default: result = '0;	// Unknown funct writes zero
			endcase
		end else begin
			case (imm_mode)
				imm_zext:  result = rdata_a | op_b;	// ORI
				imm_upper: result = op_b;	// LUI
				default:   result = rdata_a + op_b;	// Address, ADDI and LI
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid    <= 1'b0;
			ex_regwrite <= 1'b0;
			ex_memwrite <= 1'b0;
			ex_memread  <= 1'b0;
			ex_illegal  <= 1'b0;
			taken       <= 1'b0;
		end else begin
			ex_valid    <= valid;
			ex_regwrite <= regwrite;
			ex_memwrite <= memwrite;
			ex_memread  <= memread;
			ex_illegal  <= illegal;
			taken       <= valid & branch & ((rdata_a == rdata_b) ^ branch_ne);	// Low off branches
		end
	end

	always_ff @(posedge clk) begin
		ex_memtoreg <= memtoreg;
		ex_byteword <= byteword;
		ex_dest     <= dest;
		alu_result  <= result;
		store_data  <= rdata_b;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(illegal && regwrite));

endmodule

//--- hw/result_mem.sv
`timescale 1ns/1ps

module result_mem import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_valid,
	input  logic                  ex_regwrite,
	input  logic                  ex_memtoreg,
	input  logic                  ex_memwrite,
	input  logic                  ex_memread,
	input  logic                  ex_byteword,
	input  logic [reg_addr_w-1:0] ex_dest,
	input  logic                  ex_illegal,
	input  logic [data_w-1:0]     alu_result,
	input  logic [data_w-1:0]     store_data,
	input  logic                  taken,
	output logic                  wb_en,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [data_w-1:0]     wb_data,
	output logic                  retire,
	output logic                  taken_out,
	output logic                  illegal_out
);
	logic [7:0]             mem [dmem_bytes];	// Little-endian bytes
	logic [dmem_addr_w-1:0] byte_addr;
	logic [dmem_addr_w-3:0] word_idx;
	logic [data_w-1:0]      word_rd;
	logic [data_w-1:0]      load_data;

	assign byte_addr = alu_result[dmem_addr_w-1:0];	// Address wraps at the memory size
	assign word_idx  = byte_addr[dmem_addr_w-1:2];	// Word accesses drop the low two bits

	assign word_rd = {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
		mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};

	always_comb begin
		if (!ex_memread) begin
			load_data = '0;
		end else if (ex_byteword) begin
			load_data = word_rd;
		end else begin
			load_data = {{(data_w-8){mem[byte_addr][7]}}, mem[byte_addr]};	// Sign-extended byte
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dmem_bytes; i++) begin
				mem[i] <= 8'h00;
			end
		end else if (ex_valid && ex_memwrite) begin
			if (ex_byteword) begin
				mem[{word_idx, 2'd0}] <= store_data[7:0];
				mem[{word_idx, 2'd1}] <= store_data[15:8];
				mem[{word_idx, 2'd2}] <= store_data[23:16];
				mem[{word_idx, 2'd3}] <= store_data[31:24];
			end else begin
				mem[byte_addr] <= store_data[7:0];
			end
		end
	end

	// The register file takes the write at the edge that ends this stage
	assign wb_en   = ex_valid & ex_regwrite;
	assign wb_addr = ex_dest;
	assign wb_data = ex_memtoreg ? load_data : alu_result;

	assign retire      = ex_valid;
	assign taken_out   = taken;
	assign illegal_out = ex_illegal;

endmodule

//--- hw/apb_core_port.sv
`timescale 1ns/1ps

module apb_core_port import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [data_w-1:0]     pwdata,
	input  logic                  retire,
	input  logic                  taken_out,
	input  logic                  illegal_out,
	input  logic [data_w-1:0]     rdata_dbg,
	output logic [data_w-1:0]     prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  issue,
	output logic [data_w-1:0]     instr,
	output logic [reg_addr_w-1:0] raddr_dbg
);
	logic access;
	logic in_regs;
	logic wr_instr;
	logic rd_ok;
	logic busy;	// One instruction in flight
	logic done;	// Retired, transfer completes this cycle
	logic [status_w-1:0] status;

	assign access   = psel & penable;
	assign in_regs  = (paddr >= addr_reg_base) && (paddr < addr_reg_base + 12'(4 * reg_count))
		&& (paddr[1:0] == 2'b00);
	assign wr_instr = pwrite && (paddr == addr_instr);
	assign rd_ok    = !pwrite && ((paddr == addr_status) || in_regs);

	assign pready    = access & (!wr_instr | done);	// Reads and errors finish at once
	assign pslverr   = access & !wr_instr & !rd_ok;
	assign issue     = access & wr_instr & !busy & !done;
	assign instr     = pwdata;
	assign raddr_dbg = paddr[reg_addr_w+1:2];

	always_comb begin
		if (paddr == addr_status) begin
			prdata = {{(data_w-status_w){1'b0}}, status};
		end else if (in_regs) begin
			prdata = rdata_dbg;
		end else begin
			prdata = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			done   <= 1'b0;
			status <= '0;
		end else begin
			if (issue) begin
				busy <= 1'b1;
			end else if (retire) begin
				busy <= 1'b0;
			end
			if (retire) begin
				done <= 1'b1;
			end else if (access && done) begin
				done <= 1'b0;
			end
			if (retire) begin
				status[st_taken]   <= taken_out;	// Status tracks the last retired instruction
				status[st_illegal] <= illegal_out;
			end
		end
	end

	// Retire arrives in the last of the pipe_depth stage cycles
	assert property (@(posedge clk) disable iff (!rst_n) issue |-> ##(pipe_depth - 1) retire);
	assert property (@(posedge clk) disable iff (!rst_n)
		issue |=> (!issue) throughout (retire [-> 1]));

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [data_w-1:0]     pwdata,
	output logic [data_w-1:0]     prdata,
	output logic                  pready,
	output logic                  pslverr
);
	logic                  issue, retire, taken_out, illegal_out;
	logic [data_w-1:0]     instr, rdata_a, rdata_b, rdata_dbg;
	logic [reg_addr_w-1:0] raddr_a, raddr_b, raddr_dbg;
	logic                  valid, regwrite, memtoreg, branch, branch_ne;
	logic                  memwrite, memread, byteword, alusrc, illegal;
	logic [reg_addr_w-1:0] rs, rt, dest;
	logic [funct_w-1:0]    funct;
	logic [imm_w-1:0]      imm;
	logic [1:0]            imm_mode;
	logic                  ex_valid, ex_regwrite, ex_memtoreg, ex_memwrite;
	logic                  ex_memread, ex_byteword, ex_illegal, taken;
	logic [reg_addr_w-1:0] ex_dest, wb_addr;
	logic [data_w-1:0]     alu_result, store_data, wb_data;
	logic                  wb_en;

	apb_core_port u_port (.*);

	decode_ctrl u_decode (.*);

	reg_file u_regs (.clk, .rst_n, .raddr_a, .raddr_b, .raddr_dbg, .we(wb_en),
		.waddr(wb_addr), .wdata(wb_data), .rdata_a, .rdata_b, .rdata_dbg);

	execute_alu u_execute (.*);

	result_mem u_result (.*);

endmodule

//--- include/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

logic [data_w-1:0]   ref_regs [reg_count];	// Architectural registers
logic [7:0]          ref_mem [dmem_bytes];	// Little-endian data memory
logic [status_w-1:0] ref_status;
logic [31:0]         lfsr_state = 32'd98722;	// Fibonacci LFSR, seed

function automatic void ref_reset();
	foreach (ref_regs[i])
		ref_regs[i] = '0;
	foreach (ref_mem[i])
		ref_mem[i] = 8'h00;
	ref_status = '0;
endfunction

// Steps the LFSR once per bit and returns the bits taken
function automatic logic [data_w-1:0] lfsr_take(input int nbits);
	logic [data_w-1:0] bits;
	logic fb;
	bits = '0;
	for (int i = 0; i < nbits; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		bits = {bits[data_w-2:0], fb};
	end
	return bits;
endfunction

function automatic void ref_exec(input logic [data_w-1:0] ins);
	logic [reg_addr_w-1:0]  rt;
	logic [reg_addr_w-1:0]  dst;
	logic [data_w-1:0]      a, b, sx, res;
	logic [dmem_addr_w-1:0] ad, wa;
	logic                   we;
	rt  = ins[rt_msb:rt_lsb];
	a   = ref_regs[ins[rs_msb:rs_lsb]];
	b   = ref_regs[rt];
	sx  = {{(data_w-imm_w){ins[imm_msb]}}, ins[imm_msb:imm_lsb]};
	ad  = dmem_addr_w'(a + sx);
	wa  = {ad[dmem_addr_w-1:2], 2'b00};
	dst = rt;
	we  = 1'b1;
	res = '0;
	ref_status = '0;
	case (ins[op_msb:op_lsb])
		op_rtype: begin
			dst = ins[rd_msb:rd_lsb];
			case (ins[fn_msb:fn_lsb])
				fn_add:  res = a + b;
				fn_sub:  res = a - b;
				fn_and:  res = a & b;
				fn_or:   res = a | b;
				fn_slt:  res = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
				default: res = '0;
			endcase
		end
		op_ldb:  res = {{(data_w-8){ref_mem[ad][7]}}, ref_mem[ad]};
		op_ldw:  res = {ref_mem[wa+3], ref_mem[wa+2], ref_mem[wa+1], ref_mem[wa]};
		op_li:   res = sx;
		op_addi: res = a + sx;
		op_ori:  res = a | {{(data_w-imm_w){1'b0}}, ins[imm_msb:imm_lsb]};
		op_lui:  res = {ins[imm_msb:imm_lsb], {(data_w-imm_w){1'b0}}};
		default: begin
			we = 1'b0;
			case (ins[op_msb:op_lsb])
				op_stb: ref_mem[ad] = b[7:0];
				op_stw: {ref_mem[wa+3], ref_mem[wa+2], ref_mem[wa+1], ref_mem[wa]} = b;
				op_beq: ref_status[st_taken] = (a == b);
				op_bne: ref_status[st_taken] = (a != b);
				op_jump: ;
				default: ref_status[st_illegal] = 1'b1;
			endcase
		end
	endcase
	if (we && dst != '0)
		ref_regs[dst] = res;
endfunction

`endif

//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();
	localparam int clk_period     = 40;
	localparam int reset_cycles   = 3;
	localparam int n_rand         = 12;	// Random instructions per test
	localparam int instr_cycles   = pipe_depth + 1;	// One access cycle per stage, then completion
	localparam int xfer_total     = 6 * n_rand + 40 + 10 * (reg_count + 1);
	localparam int timeout_cycles = xfer_total * 8 + reset_cycles + 100;

	logic                  clk, rst_n, psel, penable, pwrite, pready, pslverr;
	logic [apb_addr_w-1:0] paddr;
	logic [data_w-1:0]     pwdata, prdata;
	logic [data_w-1:0]     got_regs [reg_count];	// Registers as read back over APB
	logic [data_w-1:0]     got_status;
	logic                  cmp_regs;
	int                    checks, errors, tests, test_start;
	string                 test_name;
	event                  compare_req, compare_done;

	`include "core_ref_model.svh"

	core_top dut_i (.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [data_w-1:0] exp, got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error %s: %s expected %h actual %h", test_name, what, exp, got);
		end
	endtask

	// Outputs are sampled on the falling edge where they have settled
	task automatic apb_transfer(input logic wr, input logic [apb_addr_w-1:0] addr,
		input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata,
		output logic err, output int cycles);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!pready);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_instr(input logic [data_w-1:0] ins);
		logic [data_w-1:0] rd;
		logic              err;
		int                cyc;
		apb_transfer(1'b1, addr_instr, ins, rd, err, cyc);
		check_value("instr pslverr", '0, err);
		check_value("instr access cycles", instr_cycles, cyc);
		ref_exec(ins);
	endtask

	task automatic read_word(input logic [apb_addr_w-1:0] addr, output logic [data_w-1:0] data);
		logic err;
		int   cyc;
		apb_transfer(1'b0, addr, '0, data, err, cyc);
		check_value("read pslverr", '0, err);
		check_value("read access cycles", 1, cyc);	// Reads finish in the first access cycle
	endtask

	// The data word is an LI to r2, so an access taken by mistake shows up in r2
	task automatic error_access(input logic wr, input logic [apb_addr_w-1:0] addr);
		logic [data_w-1:0] rd;
		logic              err;
		int                cyc;
		apb_transfer(wr, addr, {op_li, 5'd0, 5'd2, 16'h5a5a}, rd, err, cyc);
		check_value($sformatf("pslverr at %h", addr), 1, err);
		check_value("error access cycles", 1, cyc);
	endtask

	task automatic snapshot(input logic all_regs);
		logic [data_w-1:0] st;
		if (all_regs) begin
			for (int r = 0; r < reg_count; r++) begin
				read_word(addr_reg_base + apb_addr_w'(4 * r), got_regs[r]);
			end
		end
		read_word(addr_status, st);
		got_status = st;	// Whole word, the unused upper bits read as zero
		cmp_regs   = all_regs;
		-> compare_req;
		@(compare_done);
	endtask

	always @(compare_req) begin
		if (cmp_regs) begin
			for (int r = 0; r < reg_count; r++) begin
				check_value($sformatf("r%0d", r), ref_regs[r], got_regs[r]);
			end
		end
		check_value("status", data_w'(ref_status), got_status);
		-> compare_done;
	end

	task automatic start_test(input string name);
		test_name  = name;
		test_start = errors;
		tests++;
	endtask

	task automatic finish_test();
		$display("%s: %s, %0d errors", test_name, (errors == test_start) ? "ok" : "mismatch",
			errors - test_start);
	endtask

	function automatic logic [reg_addr_w-1:0] rand_reg();
		return reg_addr_w'(lfsr_take(reg_addr_w));
	endfunction

	function automatic logic [imm_w-1:0] rand_imm();
		return imm_w'(lfsr_take(imm_w));
	endfunction

	function automatic logic [data_w-1:0] enc_imm(input logic [opcode_w-1:0] op,
		input logic [reg_addr_w-1:0] rs, rt, input logic [imm_w-1:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [data_w-1:0] enc_alu(input logic [reg_addr_w-1:0] rs, rt, rd,
		input logic [funct_w-1:0] fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	initial begin
		logic [opcode_w-1:0]   imm_ops [4];
		logic [funct_w-1:0]    alu_fns [5];
		logic [imm_w-1:0]      offs [n_rand];
		logic [reg_addr_w-1:0] d;
		logic [data_w-1:0]     v;
		imm_ops = '{op_li, op_addi, op_ori, op_lui};
		alu_fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
		clk     = 1'b0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		checks  = 0;
		errors  = 0;
		tests   = 0;
		ref_reset();
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;

		start_test("immediate forms");
		for (int i = 0; i < n_rand; i++) begin
			d = (i == 2) ? '0 : rand_reg();	// One write aims at r0
			write_instr(enc_imm(imm_ops[2'(lfsr_take(2))], rand_reg(), d, rand_imm()));
		end
		snapshot(1'b1);
		finish_test();

		start_test("r-type alu");
		write_instr(enc_imm(op_li, 5'd0, 5'd1, {1'b1, 15'(lfsr_take(15))}));	// Negative
		write_instr(enc_imm(op_li, 5'd0, 5'd2, {1'b0, 15'(lfsr_take(15))}));
		write_instr(enc_alu(5'd1, 5'd2, 5'd3, fn_slt));	// Signed compare across the sign
		write_instr(enc_alu(5'd2, 5'd1, 5'd4, fn_slt));
		for (int i = 0; i < n_rand; i++) begin
			write_instr(enc_alu(rand_reg(), rand_reg(), rand_reg(), alu_fns[lfsr_take(3) % 5]));
		end
		snapshot(1'b1);
		finish_test();

		start_test("loads and stores");
		write_instr(enc_imm(op_li, 5'd0, 5'd10, imm_w'({6'(lfsr_take(6)), 2'b00})));	// Word-aligned base
		write_instr(enc_imm(op_li, 5'd0, 5'd11, {8'(lfsr_take(8)), 1'b1, 7'(lfsr_take(7))}));
		write_instr(enc_imm(op_stb, 5'd10, 5'd11, 16'h0041));
		write_instr(enc_imm(op_ldb, 5'd10, 5'd12, 16'h0041));	// Byte with bit 7 set
		write_instr(enc_imm(op_stw, 5'd10, 5'd11, 16'h0023));
		write_instr(enc_imm(op_ldw, 5'd10, 5'd13, 16'h0021));	// Same word, other low bits
		for (int i = 0; i < n_rand; i++) begin
			offs[i] = imm_w'(lfsr_take(6));
			write_instr(enc_imm(lfsr_take(1) ? op_stw : op_stb, 5'd10, rand_reg(), offs[i]));
		end
		for (int i = 0; i < n_rand; i++) begin
			d = rand_reg();
			if (d == 5'd10) begin
				d = 5'd9;	// Keep the base pointer
			end
			write_instr(enc_imm(lfsr_take(1) ? op_ldw : op_ldb, 5'd10, d,
				offs[i] ^ imm_w'(lfsr_take(2))));
		end
		snapshot(1'b1);
		finish_test();

		start_test("branches and illegal opcodes");
		v = lfsr_take(imm_w);
		write_instr(enc_imm(op_li, 5'd0, 5'd5, v[imm_w-1:0]));
		write_instr(enc_imm(op_li, 5'd0, 5'd6, v[imm_w-1:0]));
		write_instr(enc_imm(op_li, 5'd0, 5'd7, v[imm_w-1:0] ^ 16'h0001));
		for (int i = 0; i < 4; i++) begin
			write_instr(enc_imm((i < 2) ? op_beq : op_bne, 5'd5, (i % 2) ? 5'd7 : 5'd6,
				rand_imm()));
			snapshot(1'b0);
		end
		write_instr({6'h3f, 26'(lfsr_take(26))});	// Opcode outside the map
		snapshot(1'b1);
		write_instr({op_jump, 26'(lfsr_take(26))});
		snapshot(1'b1);
		finish_test();

		start_test("apb protocol");
		write_instr(enc_imm(op_li, 5'd0, 5'd1, rand_imm()));
		error_access(1'b0, addr_instr);
		error_access(1'b1, addr_status);
		error_access(1'b0, 12'h200);
		error_access(1'b1, addr_reg_base);
		error_access(1'b0, addr_reg_base + 12'h002);	// Misaligned register address
		snapshot(1'b1);
		finish_test();

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", timeout_cycles);
		$display("sim failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
hw/core_pkg.sv
hw/reg_file.sv
hw/decode_ctrl.sv
hw/execute_alu.sv
hw/result_mem.sv
hw/apb_core_port.sv
hw/core_top.sv
bench/core_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := core_tb
FILELIST := src.f
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard include/*.svh)
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
